// ==== Makefile ====
# Verilator build and run of the execute-stage testbench

VERILATOR ?= verilator
TOP       ?= armExecTb
FILELIST  ?= armExec.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing -j 0
FAIL_MSG  ?= tests failed

SOURCES := $(wildcard logic/*.sv sim/*.sv)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS FAIL_MSG"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation result: FAIL"; exit 1; \
	else \
		echo "Simulation result: PASS"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== armExec.f ====
logic/armExecPkg.sv
logic/aluCtrlIf.sv
logic/aluDecoder.sv
logic/aluDatapath.sv
logic/flagWriteback.sv
logic/armExecute.sv
sim/execModel.sv
sim/armExecTb.sv

// ==== logic/aluCtrlIf.sv ====
interface aluCtrlIf;

    logic               reverseInputs;  // Swap Rn and Op2
    logic               invertB;        // Complement second adder input
    logic               carryIn;        // Adder carry-in
    armExecPkg::aluFunc func;           // Result select
    logic               doNotWriteReg;  // Compare/test group
    armExecPkg::cvMode  cvUpdate;       // C/V update mode

    // Decoder side, drives all controls
    modport dec (
        output reverseInputs, invertB, carryIn, func, doNotWriteReg, cvUpdate
    );

    // Datapath side
    modport alu (
        input reverseInputs, invertB, carryIn, func
    );

    // Writeback side
    modport wb (
        input doNotWriteReg, cvUpdate
    );

endinterface

// ==== logic/aluDatapath.sv ====
module aluDatapath #(
    parameter int dataWidth = 32
) (
    input  logic [dataWidth-1:0] rn,           // First operand
    input  logic [dataWidth-1:0] op2,          // Shifted second operand
    aluCtrlIf.alu                ctrl,         // Decoded controls
    output logic [dataWidth-1:0] result,       // Selected result
    output logic [3:0]           resultFlags   // Candidate NZCV
);

    localparam int msb = dataWidth - 1;

    logic [dataWidth-1:0] opA;       // Adder input A
    logic [dataWidth-1:0] opBRaw;    // Second operand before inversion
    logic [dataWidth-1:0] opB;       // Adder input B
    logic [dataWidth:0]   sum;       // Sum with carry-out on top
    logic [dataWidth-1:0] andOut;
    logic [dataWidth-1:0] xorOut;
    logic [dataWidth-1:0] orOut;
    logic                 overflow;  // Signed overflow of the adder

    // Operand steering
    always_comb begin
        if (ctrl.reverseInputs) begin  // RSB, RSC
            opA    = op2;
            opBRaw = rn;
        end else begin
            opA    = rn;
            opBRaw = op2;
        end
        opB = ctrl.invertB ? ~opBRaw : opBRaw;
    end

    // Adder with carry-in, one extra bit for C
    assign sum = {1'b0, opA} + {1'b0, opB} + {{dataWidth{1'b0}}, ctrl.carryIn};

    // Same sign in, other sign out
    assign overflow = (opA[msb] == opB[msb]) && (sum[msb] != opA[msb]);

    // Logic unit in parallel with the adder
    assign andOut = opA & opB;  // Covers BIC via invertB
    assign xorOut = opA ^ opB;
    assign orOut  = opA | opB;

    // Result select
    always_comb begin
        result = sum[msb:0];
        unique case (ctrl.func)
            armExecPkg::funcAnd:  result = andOut;
            armExecPkg::funcXor:  result = xorOut;
            armExecPkg::funcSum:  result = sum[msb:0];
            armExecPkg::funcOr:   result = orOut;
            armExecPkg::funcPass: result = opB;  // MOV or MVN
            default:              result = sum[msb:0];
        endcase
    end

    // Candidate flags, writeback picks which ones land
    always_comb begin
        resultFlags                    = 4'b0000;
        resultFlags[armExecPkg::flagN] = result[msb];
        resultFlags[armExecPkg::flagZ] = (result == '0);
        resultFlags[armExecPkg::flagC] = sum[dataWidth];  // Adder carry-out
        resultFlags[armExecPkg::flagV] = overflow;
    end

    // Decoder only ever produces the five defined functions
    always_comb begin
        aFuncDefined: assert (ctrl.func inside {armExecPkg::funcAnd, armExecPkg::funcXor,
                                                 armExecPkg::funcSum, armExecPkg::funcOr,
                                                 armExecPkg::funcPass})
            else $error("aluDatapath: undefined ALU function %0d", ctrl.func);
    end

endmodule

// ==== logic/aluDecoder.sv ====
module aluDecoder (
    input  armExecPkg::dpOpcode opcode,     // Opcode of current operation
    input  logic                carryFlag,  // Stored C from writeback
    aluCtrlIf.dec               ctrl        // Decoded controls
);

    // Operand steering and carry-in
    always_comb begin
        ctrl.reverseInputs = 1'b0;
        ctrl.invertB       = 1'b0;
        ctrl.carryIn       = 1'b0;
        unique case (opcode)
            armExecPkg::opSub,
            armExecPkg::opCmp: begin  // Rn + ~Op2 + 1
                ctrl.invertB = 1'b1;
                ctrl.carryIn = 1'b1;
            end
            armExecPkg::opRsb: begin  // Op2 + ~Rn + 1
                ctrl.reverseInputs = 1'b1;
                ctrl.invertB       = 1'b1;
                ctrl.carryIn       = 1'b1;
            end
            armExecPkg::opAdc: begin
                ctrl.carryIn = carryFlag;  // Chained add
            end
            armExecPkg::opSbc: begin  // Borrow is !C
                ctrl.invertB = 1'b1;
                ctrl.carryIn = carryFlag;
            end
            armExecPkg::opRsc: begin
                ctrl.reverseInputs = 1'b1;
                ctrl.invertB       = 1'b1;
                ctrl.carryIn       = carryFlag;
            end
            armExecPkg::opBic,
            armExecPkg::opMvn: begin
                ctrl.invertB = 1'b1;  // Complemented Op2 into logic unit
            end
            armExecPkg::opAnd, armExecPkg::opEor, armExecPkg::opAdd,
            armExecPkg::opTst, armExecPkg::opTeq, armExecPkg::opCmn,
            armExecPkg::opOrr, armExecPkg::opMov: begin
                ctrl.carryIn = 1'b0;  // Plain operands
            end
        endcase
    end

    // Function select, register write and flag mode
    always_comb begin
        ctrl.func          = armExecPkg::funcSum;
        ctrl.doNotWriteReg = 1'b0;
        ctrl.cvUpdate      = armExecPkg::cvKeep;
        unique case (opcode)
            armExecPkg::opAnd,
            armExecPkg::opBic: ctrl.func = armExecPkg::funcAnd;
            armExecPkg::opTst: begin
                ctrl.func          = armExecPkg::funcAnd;
                ctrl.doNotWriteReg = 1'b1;  // Flags only
            end
            armExecPkg::opEor: ctrl.func = armExecPkg::funcXor;
            armExecPkg::opTeq: begin
                ctrl.func          = armExecPkg::funcXor;
                ctrl.doNotWriteReg = 1'b1;
            end
            armExecPkg::opOrr: ctrl.func = armExecPkg::funcOr;
            armExecPkg::opMov,
            armExecPkg::opMvn: ctrl.func = armExecPkg::funcPass;
            armExecPkg::opCmp,
            armExecPkg::opCmn: begin  // Adder without writeback
                ctrl.func          = armExecPkg::funcSum;
                ctrl.doNotWriteReg = 1'b1;
                ctrl.cvUpdate      = armExecPkg::cvArith;
            end
            armExecPkg::opSub, armExecPkg::opRsb, armExecPkg::opAdd,
            armExecPkg::opAdc, armExecPkg::opSbc, armExecPkg::opRsc: begin
                ctrl.func     = armExecPkg::funcSum;
                ctrl.cvUpdate = armExecPkg::cvArith;  // C and V from adder
            end
        endcase
    end

endmodule

// ==== logic/armExecPkg.sv ====
package armExecPkg;

    // Data-processing opcodes, ARM instruction bits 24:21
    typedef enum logic [3:0] {
        opAnd = 4'd0,   // Rn & Op2
        opEor = 4'd1,   // Rn ^ Op2
        opSub = 4'd2,   // Rn - Op2
        opRsb = 4'd3,   // Op2 - Rn
        opAdd = 4'd4,   // Rn + Op2
        opAdc = 4'd5,   // Rn + Op2 + C
        opSbc = 4'd6,   // Rn - Op2 - !C
        opRsc = 4'd7,   // Op2 - Rn - !C
        opTst = 4'd8,   // AND, flags only
        opTeq = 4'd9,   // EOR, flags only
        opCmp = 4'd10,  // SUB, flags only
        opCmn = 4'd11,  // ADD, flags only
        opOrr = 4'd12,  // Rn | Op2
        opMov = 4'd13,  // Op2
        opBic = 4'd14,  // Rn & ~Op2
        opMvn = 4'd15   // ~Op2
    } dpOpcode;

    // Function select of the ALU result mux
    typedef enum logic [2:0] {
        funcAnd  = 3'd0,  // Bitwise and
        funcXor  = 3'd1,  // Bitwise exclusive or
        funcSum  = 3'd2,  // Adder output
        funcOr   = 3'd3,  // Bitwise or
        funcPass = 3'd4   // Second operand only
    } aluFunc;

    // How C and V react to a flag-setting operation
    typedef enum logic {
        cvKeep  = 1'b0,   // Logical ops, C and V hold
        cvArith = 1'b1    // Adder ops, C and V from adder
    } cvMode;

    // Bit positions inside the NZCV vector
    localparam int flagN = 3;  // Negative
    localparam int flagZ = 2;  // Zero
    localparam int flagC = 1;  // Carry
    localparam int flagV = 0;  // Overflow

endpackage

// ==== logic/armExecute.sv ====
module armExecute #(
    parameter int dataWidth = 32
) (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 opValid,      // One operation per strobe
    input  logic [3:0]           opcode,       // Data-processing opcode
    input  logic                 setFlags,     // S bit
    input  logic [dataWidth-1:0] rn,           // First operand
    input  logic [dataWidth-1:0] op2,          // Already-shifted operand
    output logic                 resultValid,  // Result strobe, one cycle later
    output logic [dataWidth-1:0] result,
    output logic                 writeReg,     // Result goes to Rd
    output logic [3:0]           flags         // NZCV
);

    logic [dataWidth-1:0] aluResult;  // Datapath result
    logic [3:0]           aluFlags;   // Candidate NZCV
    logic                 carryFlag;  // Stored C for carry chaining

    // Decoded controls shared by all three blocks
    aluCtrlIf ctrl0 ();

    aluDecoder dec0 (
        .opcode    (armExecPkg::dpOpcode'(opcode)),
        .carryFlag (carryFlag),
        .ctrl      (ctrl0.dec)
    );

    aluDatapath #(
        .dataWidth (dataWidth)
    ) alu0 (
        .rn          (rn),
        .op2         (op2),
        .ctrl        (ctrl0.alu),
        .result      (aluResult),
        .resultFlags (aluFlags)
    );

    flagWriteback #(
        .dataWidth (dataWidth)
    ) wb0 (
        .clk         (clk),
        .arstN       (arstN),
        .opValid     (opValid),
        .setFlags    (setFlags),
        .result      (aluResult),
        .resultFlags (aluFlags),
        .ctrl        (ctrl0.wb),
        .resultValid (resultValid),
        .resultOut   (result),
        .writeReg    (writeReg),
        .flags       (flags),
        .carryFlag   (carryFlag)
    );

endmodule

// ==== logic/flagWriteback.sv ====
module flagWriteback #(
    parameter int dataWidth = 32
) (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 opValid,      // Operation strobe
    input  logic                 setFlags,     // S bit
    input  logic [dataWidth-1:0] result,       // From datapath
    input  logic [3:0]           resultFlags,  // Candidate NZCV
    aluCtrlIf.wb                 ctrl,         // Write and flag controls
    output logic                 resultValid,  // One-cycle pulse
    output logic [dataWidth-1:0] resultOut,    // Registered result
    output logic                 writeReg,     // Register file write enable
    output logic [3:0]           flags,        // Stored NZCV
    output logic                 carryFlag     // Stored C to decoder
);

    logic flagUpdate;  // Flag-setting operation this cycle

    assign flagUpdate = opValid && setFlags;

    // Result stage
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            resultValid <= 1'b0;
            resultOut   <= '0;
            writeReg    <= 1'b0;
        end else begin
            resultValid <= opValid;  // Pulse follows strobe by one cycle
            if (opValid) begin
                resultOut <= result;
                writeReg  <= !ctrl.doNotWriteReg;  // Low for TST/TEQ/CMP/CMN
            end
        end
    end

    // NZCV register
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            flags <= 4'b0000;
        end else if (flagUpdate) begin
            flags[armExecPkg::flagN] <= resultFlags[armExecPkg::flagN];
            flags[armExecPkg::flagZ] <= resultFlags[armExecPkg::flagZ];
            if (ctrl.cvUpdate == armExecPkg::cvArith) begin  // Logical ops keep C, V
                flags[armExecPkg::flagC] <= resultFlags[armExecPkg::flagC];
                flags[armExecPkg::flagV] <= resultFlags[armExecPkg::flagV];
            end
        end
    end

    // Back to decoder for ADC/SBC/RSC
    assign carryFlag = flags[armExecPkg::flagC];

    // Back-to-back pulses only from back-to-back strobes
    aValidPulse: assert property (
        @(posedge clk) disable iff (!arstN)
        (resultValid && $past(resultValid)) |-> ($past(opValid) && $past(opValid, 2))
    ) else $error("flagWriteback: resultValid held without consecutive opValid");

    // Flags move only after a flag-setting operation
    aFlagsStable: assert property (
        @(posedge clk) disable iff (!arstN)
        !$past(flagUpdate) |-> $stable(flags)
    ) else $error("flagWriteback: flags changed without opValid and setFlags");

endmodule

// ==== sim/armExecTb.sv ====
module armExecTb;

    localparam int dataWidth   = 32;
    localparam int resetCycles = 3;
    localparam int logicOps    = 300;
    localparam int addOps      = 400;
    localparam int carryOps    = 400;
    localparam int compareOps  = 300;
    localparam int strobeOps   = 200;
    localparam int maxGap      = 3;  // Idle cycles after a strobe-test op
    // One cycle per op, gaps in the strobe test, two drain cycles per test
    localparam int cycleLimit  = logicOps + addOps + carryOps + compareOps
                                 + strobeOps * (maxGap + 1) + resetCycles + 5 * 2 + 50;

    logic                 clk;
    logic                 arstN;
    logic                 opValid;
    logic [3:0]           opcode;
    logic                 setFlags;
    logic [dataWidth-1:0] rn;
    logic [dataWidth-1:0] op2;
    logic                 resultValid;
    logic [dataWidth-1:0] result;
    logic                 writeReg;
    logic [3:0]           flags;

    integer               seed;
    int                   cycleCount = 0;
    int                   errorCount = 0;
    int                   checkCount = 0;
    int                   testsRun   = 0;
    int                   testsClean = 0;
    string                testName   = "reset";
    logic                 lastValid  = 1'b0;     // opValid the DUT sampled last edge
    logic                 lastFlagOp = 1'b0;
    logic [3:0]           lastFlags  = 4'b0000;
    logic [dataWidth-1:0] expResultQ[$];         // Expected per op, in issue order
    logic                 expWriteQ[$];
    logic [3:0]           expFlagsQ[$];

    armExecute #(
        .dataWidth (dataWidth)
    ) dut0 (
        .clk         (clk),
        .arstN       (arstN),
        .opValid     (opValid),
        .opcode      (opcode),
        .setFlags    (setFlags),
        .rn          (rn),
        .op2         (op2),
        .resultValid (resultValid),
        .result      (result),
        .writeReg    (writeReg),
        .flags       (flags)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: run did not finish within %0d cycles", cycleLimit);
            $display("tests failed");
            $finish;
        end
    end

    function automatic logic [31:0] randWord();
        return $random(seed);
    endfunction

    // Biased toward 0, all ones and the sign boundaries
    function automatic logic [31:0] pickOperand(input bit edges);
        logic [31:0] r;
        r = randWord();
        if (!edges) return randWord();
        case (r[2:0])
            3'd0:    return 32'h0000_0000;
            3'd1:    return 32'hFFFF_FFFF;
            3'd2:    return 32'h8000_0000;
            3'd3:    return 32'h7FFF_FFFF;
            default: return randWord();
        endcase
    endfunction

    // Compare one finished operation with the head of the queue
    task automatic checkResult();
        logic [dataWidth-1:0] expResult;
        logic                 expWrite;
        logic [3:0]           expFlags;
        assert (expResultQ.size() != 0) else begin
            errorCount++;
            $display("%s: resultValid went high with no operation outstanding", testName);
        end
        if (expResultQ.size() != 0) begin
            expResult = expResultQ.pop_front();
            expWrite  = expWriteQ.pop_front();
            expFlags  = expFlagsQ.pop_front();
            checkCount++;
            assert (writeReg == expWrite) else begin
                errorCount++;
                $display("[ERROR] %s: writeReg expected %0b, actual %0b",
                         testName, expWrite, writeReg);
            end
            assert (!expWrite || result == expResult) else begin  // Compare ops skip Rd
                errorCount++;
                $display("[ERROR] %s: result expected %h, actual %h",
                         testName, expResult, result);
            end
            assert (flags == expFlags) else begin
                errorCount++;
                $display("[ERROR] %s: flags expected %b, actual %b", testName, expFlags, flags);
            end
        end
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (arstN) begin
            assert (resultValid == lastValid) else begin
                errorCount++;
                $display("[ERROR] %s: resultValid expected %0b, actual %0b",
                         testName, lastValid, resultValid);
            end
            assert (lastFlagOp || flags == lastFlags) else begin  // No S op, no change
                errorCount++;
                $display("[ERROR] %s: flags expected %b, actual %b", testName, lastFlags, flags);
            end
            if (resultValid) begin
                checkResult();
            end
        end
        lastValid  = opValid;
        lastFlagOp = opValid && setFlags;
        lastFlags  = flags;
    end

    task automatic issueOp(input armExecPkg::dpOpcode op, input logic s,
                           input logic [31:0] a, input logic [31:0] b);
        logic [31:0] expResult;
        logic        expWrite;
        logic [3:0]  expFlags;
        @(posedge clk);
        opValid  <= 1'b1;
        opcode   <= op;
        setFlags <= s;
        rn       <= a;
        op2      <= b;
        execModel::execute(op, s, a, b, expResult, expWrite, expFlags);
        expResultQ.push_back(expResult);
        expWriteQ.push_back(expWrite);
        expFlagsQ.push_back(expFlags);
    endtask

    // Garbage on the data inputs while opValid is low
    task automatic idleCycle();
        logic [31:0] r;
        r = randWord();
        @(posedge clk);
        opValid  <= 1'b0;
        opcode   <= r[7:4];
        setFlags <= r[0];
        rn       <= randWord();
        op2      <= randWord();
    endtask

    // Opcode drawn from the set bits of mask, S set with chance sLevel/4
    task automatic issueRandom(input logic [15:0] mask, input bit edges, input int sLevel);
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] b;
        r = randWord();
        while (!mask[r[3:0]]) begin
            r = randWord();
        end
        a = pickOperand(edges);
        b = pickOperand(edges);
        issueOp(armExecPkg::dpOpcode'(r[3:0]), int'(r[9:8]) < sLevel, a, b);
    endtask

    task automatic finishTest(input int count, input int errorsBefore);
        int errors;
        idleCycle();
        while (expResultQ.size() != 0) begin
            @(posedge clk);
        end
        errors = errorCount - errorsBefore;
        testsRun++;
        if (errors == 0) testsClean++;
        $display("%s: %0d operations, %0d errors", testName, count, errors);
    endtask

    task automatic runGroup(input string name, input logic [15:0] mask, input int count,
                            input bit edges, input int sLevel, input bit gaps);
        int          errorsBefore;
        logic [31:0] r;
        errorsBefore = errorCount;
        testName     = name;
        for (int i = 0; i < count; i++) begin
            issueRandom(mask, edges, sLevel);
            r = randWord();
            if (gaps) begin
                repeat (int'(r[1:0])) idleCycle();  // 0 to maxGap idle cycles
            end
        end
        finishTest(count, errorsBefore);
    endtask

    // Every fourth op seeds C with ADD/SUB/CMP/CMN, the rest chain on it
    task automatic runCarryChain(input string name, input int count);
        int errorsBefore;
        errorsBefore = errorCount;
        testName     = name;
        for (int i = 0; i < count; i++) begin
            if (i % 4 == 0) issueRandom(16'h0C14, 1'b1, 4);
            else issueRandom(16'h00E0, 1'b1, 3);  // ADC, SBC, RSC
        end
        finishTest(count, errorsBefore);
    endtask

    initial begin
        seed     = 32'h46bb3352;
        arstN    = 1'b0;
        opValid  = 1'b0;
        opcode   = 4'h0;
        setFlags = 1'b0;
        rn       = '0;
        op2      = '0;
        execModel::resetFlags();
        repeat (resetCycles) @(posedge clk);
        arstN <= 1'b1;

        runGroup("logical", 16'hF003, logicOps, 1'b0, 2, 1'b0);  // AND EOR ORR MOV BIC MVN
        runGroup("addSub", 16'h001C, addOps, 1'b1, 3, 1'b0);     // SUB RSB ADD
        runCarryChain("carryChain", carryOps);
        runGroup("compare", 16'h0F00, compareOps, 1'b1, 2, 1'b0);  // TST TEQ CMP CMN
        runGroup("strobe", 16'hFFFF, strobeOps, 1'b1, 2, 1'b1);

        $display("Summary: %0d tests, %0d clean, %0d operations checked, %0d errors",
                 testsRun, testsClean, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== sim/execModel.sv ====
package execModel;

    localparam longint wordSpan  = 64'sd4294967296;  // 2**32
    localparam longint maxSigned = 64'sd2147483647;
    localparam longint minSigned = -64'sd2147483648;

    logic [3:0] nzcv;  // Model NZCV state

    function automatic void resetFlags();
        nzcv = 4'b0000;
    endfunction

    // Exact a + b + cin, C when the unsigned sum leaves 32 bits
    function automatic void addExact(input logic [31:0] a, input logic [31:0] b,
                                     input logic cin, output logic [31:0] res,
                                     output logic c, output logic v);
        longint uSum;
        longint sSum;
        uSum = longint'({32'b0, a}) + longint'({32'b0, b}) + longint'({63'b0, cin});
        sSum = longint'({{32{a[31]}}, a}) + longint'({{32{b[31]}}, b})
               + longint'({63'b0, cin});
        res  = uSum[31:0];
        c    = (uSum >= wordSpan);
        v    = (sSum > maxSigned) || (sSum < minSigned);  // Signed result out of range
    endfunction

    // Exact a - b - borrow, C is set when nothing was borrowed
    function automatic void subExact(input logic [31:0] a, input logic [31:0] b,
                                     input logic borrow, output logic [31:0] res,
                                     output logic c, output logic v);
        longint uDiff;
        longint sDiff;
        uDiff = longint'({32'b0, a}) - longint'({32'b0, b}) - longint'({63'b0, borrow});
        sDiff = longint'({{32{a[31]}}, a}) - longint'({{32{b[31]}}, b})
                - longint'({63'b0, borrow});
        res   = uDiff[31:0];
        c     = (uDiff >= 0);
        v     = (sDiff > maxSigned) || (sDiff < minSigned);
    endfunction

    // One data-processing instruction against the model state
    function automatic void execute(input armExecPkg::dpOpcode op, input logic s,
                                    input logic [31:0] rn, input logic [31:0] op2,
                                    output logic [31:0] res, output logic wr,
                                    output logic [3:0] flagsOut);
        logic cOld;
        logic c;
        logic v;
        logic arith;
        cOld  = nzcv[armExecPkg::flagC];
        c     = cOld;
        v     = nzcv[armExecPkg::flagV];
        arith = 1'b1;  // Cleared below for logical ops
        wr    = !(op inside {armExecPkg::opTst, armExecPkg::opTeq,
                             armExecPkg::opCmp, armExecPkg::opCmn});
        res   = '0;
        case (op)
            armExecPkg::opSub, armExecPkg::opCmp: subExact(rn, op2, 1'b0, res, c, v);
            armExecPkg::opRsb: subExact(op2, rn, 1'b0, res, c, v);
            armExecPkg::opAdd, armExecPkg::opCmn: addExact(rn, op2, 1'b0, res, c, v);
            armExecPkg::opAdc: addExact(rn, op2, cOld, res, c, v);
            armExecPkg::opSbc: subExact(rn, op2, !cOld, res, c, v);  // Borrow is not C
            armExecPkg::opRsc: subExact(op2, rn, !cOld, res, c, v);
            default: begin
                arith = 1'b0;
                case (op)
                    armExecPkg::opAnd, armExecPkg::opTst: res = rn & op2;
                    armExecPkg::opEor, armExecPkg::opTeq: res = rn ^ op2;
                    armExecPkg::opOrr: res = rn | op2;
                    armExecPkg::opBic: res = rn & ~op2;
                    armExecPkg::opMvn: res = ~op2;
                    default:           res = op2;  // MOV
                endcase
            end
        endcase
        if (s) begin
            nzcv[armExecPkg::flagN] = res[31];
            nzcv[armExecPkg::flagZ] = (res == 32'h0);
            if (arith) begin  // No shifter carry, logical ops hold C
                nzcv[armExecPkg::flagC] = c;
                nzcv[armExecPkg::flagV] = v;
            end
        end
        flagsOut = nzcv;
    endfunction

endpackage
